/* source/ext_periph_pkg.sv */
// Shared widths, address map, register offsets and sequencer states
// for the external peripheral block. Imported by every RTL file.
package ext_periph_pkg;

  localparam int unsigned ADDR_WIDTH = 12;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned CNT_WIDTH  = 16;

  // Offset bits inside one target region of 0x100 bytes
  localparam int unsigned REGION_WIDTH = 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [CNT_WIDTH-1:0]  cnt_t;

  // Target base addresses
  localparam addr_t PWR_BASE  = 12'h000;
  localparam addr_t GPIO_BASE = 12'h100;

  // Power control registers
  localparam addr_t PWR_CTRL_OFS   = 12'h000;
  localparam addr_t PWR_STATUS_OFS = 12'h004;

  // GPIO counter registers
  localparam addr_t GPIO_MAX_OFS   = 12'h000;
  localparam addr_t GPIO_COUNT_OFS = 12'h004;
  localparam cnt_t  GPIO_MAX_RESET = 16'd4;

  typedef enum logic [2:0] {
    PWR_OFF,
    PWR_SW_ON,
    PWR_RST_REL,
    PWR_ISO_REL,
    PWR_ON,
    PWR_ISO_SET,
    PWR_RST_SET,
    PWR_SW_OFF
  } pwr_state_e;

endpackage

/* source/reg_bus_if.sv */
// Zero-wait register bus. The host drives a request in any cycle with valid
// high; the device answers with rdata and error in the same cycle.
interface reg_bus_if import ext_periph_pkg::*; ();

  logic  valid;
  logic  write;
  addr_t addr;
  data_t wdata;
  data_t rdata;
  logic  error;

  modport host (
    output valid,
    output write,
    output addr,
    output wdata,
    input  rdata,
    input  error
  );

  modport device (
    input  valid,
    input  write,
    input  addr,
    input  wdata,
    output rdata,
    output error
  );

endinterface

/* source/reg_demux.sv */
// Routes one host register bus to the power and GPIO targets by address.
// Unmapped accesses return error with zero data and reach no target.
module reg_demux import ext_periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  reg_bus_if.device host_bus,
  reg_bus_if.host   pwr_bus,
  reg_bus_if.host   gpio_bus
);

  logic [ADDR_WIDTH-REGION_WIDTH-1:0] region;
  logic                               sel_pwr;
  logic                               sel_gpio;
  addr_t                              local_addr;

  assign region   = host_bus.addr[ADDR_WIDTH-1:REGION_WIDTH];
  assign sel_pwr  = (region == PWR_BASE[ADDR_WIDTH-1:REGION_WIDTH]);
  assign sel_gpio = (region == GPIO_BASE[ADDR_WIDTH-1:REGION_WIDTH]);

  // Targets see offsets only
  assign local_addr = addr_t'(host_bus.addr[REGION_WIDTH-1:0]);

  assign pwr_bus.valid = host_bus.valid && sel_pwr;
  assign pwr_bus.write = host_bus.write;
  assign pwr_bus.addr  = local_addr;
  assign pwr_bus.wdata = host_bus.wdata;

  assign gpio_bus.valid = host_bus.valid && sel_gpio;
  assign gpio_bus.write = host_bus.write;
  assign gpio_bus.addr  = local_addr;
  assign gpio_bus.wdata = host_bus.wdata;

  always_comb begin
    if (sel_pwr) begin
      host_bus.rdata = pwr_bus.rdata;
      host_bus.error = pwr_bus.error;
    end else if (sel_gpio) begin
      host_bus.rdata = gpio_bus.rdata;
      host_bus.error = gpio_bus.error;
    end else begin
      // Outside both regions
      host_bus.rdata = '0;
      host_bus.error = host_bus.valid;
    end
  end

  a_one_target: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(pwr_bus.valid && gpio_bus.valid)
  );

endmodule

/* source/power_ctrl_regs.sv */
// Power-domain register block: one on-request bit per domain in the control
// register, and a read-only status register fed back by the sequencers.
module power_ctrl_regs import ext_periph_pkg::*; #(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  reg_bus_if.device              bus,
  output logic [NUM_DOMAINS-1:0] on_req_o,
  input  logic [NUM_DOMAINS-1:0] on_status_i
);

  logic [NUM_DOMAINS-1:0] ctrl_q;
  logic                   hit_ctrl;
  logic                   hit_status;

  assign hit_ctrl   = (bus.addr == PWR_CTRL_OFS);
  assign hit_status = (bus.addr == PWR_STATUS_OFS);

  // All domains requested off after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (bus.valid && bus.write && hit_ctrl) begin
      ctrl_q <= bus.wdata[NUM_DOMAINS-1:0];
    end
  end

  always_comb begin
    if (hit_ctrl) begin
      bus.rdata = data_t'(ctrl_q);
    end else if (hit_status) begin
      bus.rdata = data_t'(on_status_i);
    end else begin
      bus.rdata = '0;
    end
  end

  // Status writes are dropped silently, unknown offsets flag an error
  assign bus.error = bus.valid && !(hit_ctrl || hit_status);

  assign on_req_o = ctrl_q;

endmodule

/* source/power_seq.sv */
// Sequencer for one external power domain. Orders switch, reset and
// isolation on power-up and power-down, waiting for the switch acknowledge.
module power_seq import ext_periph_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic on_req_i,
  input  logic switch_ack_i,
  output logic switch_o,
  output logic iso_o,
  output logic dom_rst_n_o,
  output logic on_o
);

  pwr_state_e state_q;
  pwr_state_e state_d;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= PWR_OFF;
    end else begin
      state_q <= state_d;
    end
  end

  // Requests are sampled only in PWR_OFF and PWR_ON
  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_OFF:     if (on_req_i) state_d = PWR_SW_ON;
      PWR_SW_ON:   state_d = switch_ack_i ? PWR_ISO_REL : PWR_RST_REL;
      PWR_RST_REL: if (switch_ack_i) state_d = PWR_ISO_REL;
      PWR_ISO_REL: state_d = PWR_ON;
      PWR_ON:      if (!on_req_i) state_d = PWR_ISO_SET;
      PWR_ISO_SET: state_d = PWR_RST_SET;
      PWR_RST_SET: state_d = PWR_SW_OFF;
      PWR_SW_OFF:  if (!switch_ack_i) state_d = PWR_OFF;
      default:     state_d = PWR_OFF;
    endcase
  end

  // RST_REL waits for ack, ISO_REL has reset out but isolation still on
  always_comb begin
    switch_o    = 1'b1;
    dom_rst_n_o = 1'b0;
    iso_o       = 1'b1;
    case (state_q)
      PWR_OFF,
      PWR_SW_OFF: switch_o = 1'b0;
      PWR_ISO_REL,
      PWR_ISO_SET: dom_rst_n_o = 1'b1;
      PWR_ON: begin
        dom_rst_n_o = 1'b1;
        iso_o       = 1'b0;
      end
      default: ;
    endcase
  end

  assign on_o = (state_q == PWR_ON);

  a_iso_when_off: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !switch_o |-> iso_o
  );

  a_rst_when_off: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !switch_o |-> !dom_rst_n_o
  );

endmodule

/* source/gpio_cnt.sv */
// Counts rising edges on gpio_i and toggles gpio_o each time the programmed
// limit is reached. Limit and current count are reachable over the bus.
module gpio_cnt import ext_periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  reg_bus_if.device bus,
  input  logic      gpio_i,
  output logic      gpio_o
);

  cnt_t max_q;
  cnt_t count_q;
  cnt_t count_inc;
  cnt_t limit;
  logic gpio_q;
  logic edge_seen;
  logic hit_max;
  logic hit_count;

  assign edge_seen = gpio_i && !gpio_q;
  assign count_inc = count_q + cnt_t'(1);
  // Zero limit behaves as one
  assign limit     = (max_q == '0) ? cnt_t'(1) : max_q;

  assign hit_max   = (bus.addr == GPIO_MAX_OFS);
  assign hit_count = (bus.addr == GPIO_COUNT_OFS);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      max_q   <= GPIO_MAX_RESET;
      count_q <= '0;
      gpio_q  <= 1'b0;
      gpio_o  <= 1'b0;
    end else begin
      gpio_q <= gpio_i;
      if (bus.valid && bus.write && hit_max) begin
        max_q <= bus.wdata[CNT_WIDTH-1:0];
      end
      if (edge_seen) begin
        if (count_inc >= limit) begin
          count_q <= '0;
          gpio_o  <= !gpio_o;
        end else begin
          count_q <= count_inc;
        end
      end
    end
  end

  always_comb begin
    if (hit_max) begin
      bus.rdata = data_t'(max_q);
    end else if (hit_count) begin
      bus.rdata = data_t'(count_q);
    end else begin
      bus.rdata = '0;
    end
  end

  assign bus.error = bus.valid && !(hit_max || hit_count);

endmodule

/* source/ext_periph_top.sv */
// External peripheral block top level. Plain register bus and pin ports,
// internally a demux feeding power-domain control and the GPIO counter.
module ext_periph_top import ext_periph_pkg::*; #(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  addr_t                  reg_addr_i,
  input  data_t                  reg_wdata_i,
  output data_t                  reg_rdata_o,
  output logic                   reg_error_o,
  input  logic [NUM_DOMAINS-1:0] switch_ack_i,
  output logic [NUM_DOMAINS-1:0] switch_o,
  output logic [NUM_DOMAINS-1:0] iso_o,
  output logic [NUM_DOMAINS-1:0] dom_rst_n_o,
  input  logic                   gpio_i,
  output logic                   gpio_o
);

  reg_bus_if host_bus ();
  reg_bus_if pwr_bus ();
  reg_bus_if gpio_bus ();

  logic [NUM_DOMAINS-1:0] on_req;
  logic [NUM_DOMAINS-1:0] on_status;

  assign host_bus.valid = reg_valid_i;
  assign host_bus.write = reg_write_i;
  assign host_bus.addr  = reg_addr_i;
  assign host_bus.wdata = reg_wdata_i;
  assign reg_rdata_o    = host_bus.rdata;
  assign reg_error_o    = host_bus.error;

  reg_demux reg_demux_i (
    .clk_i,
    .rst_n_i,
    .host_bus (host_bus),
    .pwr_bus  (pwr_bus),
    .gpio_bus (gpio_bus)
  );

  power_ctrl_regs #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) power_ctrl_regs_i (
    .clk_i,
    .rst_n_i,
    .bus         (pwr_bus),
    .on_req_o    (on_req),
    .on_status_i (on_status)
  );

  // One sequencer per external domain
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_domain
    power_seq power_seq_i (
      .clk_i,
      .rst_n_i,
      .on_req_i     (on_req[d]),
      .switch_ack_i (switch_ack_i[d]),
      .switch_o     (switch_o[d]),
      .iso_o        (iso_o[d]),
      .dom_rst_n_o  (dom_rst_n_o[d]),
      .on_o         (on_status[d])
    );
  end

  gpio_cnt gpio_cnt_i (
    .clk_i,
    .rst_n_i,
    .bus    (gpio_bus),
    .gpio_i,
    .gpio_o
  );

endmodule

/* test/ext_periph_checker.sv */
// Watches the external peripheral ports, models GPIO counting and power pin order,
// and compares bus responses with the expectations driven by the testbench.
module ext_periph_checker #(
  parameter int NUM_DOMAINS = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  logic                   write_i,
  input  logic [11:0]            addr_i,
  input  logic [31:0]            wdata_i,
  input  logic [31:0]            rdata_i,
  input  logic                   error_i,
  input  logic [NUM_DOMAINS-1:0] ack_i,
  input  logic [NUM_DOMAINS-1:0] switch_i,
  input  logic [NUM_DOMAINS-1:0] iso_i,
  input  logic [NUM_DOMAINS-1:0] dom_rst_n_i,
  input  logic                   gpio_in_i,
  input  logic                   gpio_out_i,
  input  logic                   chk_en_i,
  input  logic [31:0]            exp_rdata_i,
  input  logic                   exp_error_i,
  output int                     err_cnt_o
);

  localparam logic [11:0] ADDR_PWR_CTRL   = 12'h000;
  localparam logic [11:0] ADDR_PWR_STATUS = 12'h004;
  localparam logic [11:0] ADDR_GPIO_MAX   = 12'h100;

  logic [15:0]            limit_m;
  logic [15:0]            count_m;
  logic                   gpio_m;
  logic                   gpio_prev;
  logic [NUM_DOMAINS-1:0] req_m;
  logic [NUM_DOMAINS-1:0] sw_q;
  logic [NUM_DOMAINS-1:0] iso_q;
  logic [NUM_DOMAINS-1:0] rst_q;
  logic [NUM_DOMAINS-1:0] ack_q;
  logic [NUM_DOMAINS-1:0] off_step1;
  logic [NUM_DOMAINS-1:0] off_step2;
  logic                   after_rst = 1'b0;
  int                     errors = 0;

  assign err_cnt_o = errors;

  task automatic log_error(input string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  // Sampled mid-cycle, after the rising-edge drive has settled
  always @(negedge clk_i) begin : watch
    logic [15:0] lim;
    if (!rst_n_i) begin
      limit_m   = 16'd4;
      count_m   = '0;
      gpio_m    = 1'b0;
      gpio_prev = 1'b0;
      req_m     = '0;
      sw_q      = '0;
      iso_q     = '1;
      rst_q     = '0;
      ack_q     = '0;
      off_step1 = '0;
      off_step2 = '0;
      after_rst = 1'b1;
    end else begin
      if (after_rst && (switch_i != '0 || iso_i != '1 || dom_rst_n_i != '0)) begin
        log_error("power pins not at reset values");
      end
      after_rst = 1'b0;
      if (chk_en_i) begin
        if (error_i !== exp_error_i) begin
          log_error($sformatf("addr %h error %b, expected %b", addr_i, error_i, exp_error_i));
        end
        if (!write_i && rdata_i !== exp_rdata_i) begin
          log_error($sformatf("addr %h rdata %h, expected %h", addr_i, rdata_i, exp_rdata_i));
        end
      end
      // Status must follow isolation release of each domain
      if (valid_i && !write_i && addr_i == ADDR_PWR_STATUS) begin
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          if (rdata_i[d] !== !iso_i[d]) begin
            log_error($sformatf("status bit %0d does not match isolation", d));
          end
        end
      end
      if (gpio_out_i !== gpio_m) begin
        log_error($sformatf("gpio_o %b, expected %b", gpio_out_i, gpio_m));
      end
      lim = (limit_m == 16'd0) ? 16'd1 : limit_m;
      if (gpio_in_i && !gpio_prev) begin
        if (count_m + 16'd1 == lim) begin
          count_m = '0;
          gpio_m  = !gpio_m;
        end else begin
          count_m = count_m + 16'd1;
        end
      end
      gpio_prev = gpio_in_i;
      if (valid_i && write_i && addr_i == ADDR_GPIO_MAX) begin
        limit_m = wdata_i[15:0];
      end
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (!switch_i[d] && (!iso_i[d] || dom_rst_n_i[d])) begin
          log_error($sformatf("domain %0d released while switch low", d));
        end
        if (switch_i[d] && !sw_q[d] && !req_m[d]) begin
          log_error($sformatf("domain %0d switch rose without request", d));
        end
        if (dom_rst_n_i[d] && !rst_q[d] && !(sw_q[d] && ack_q[d])) begin
          log_error($sformatf("domain %0d reset released before ack", d));
        end
        if (!iso_i[d] && iso_q[d] && !rst_q[d]) begin
          log_error($sformatf("domain %0d isolation released before reset", d));
        end
        if (off_step1[d]) begin
          if (dom_rst_n_i[d] || !switch_i[d]) begin
            log_error($sformatf("domain %0d reset did not fall after isolation", d));
          end
          off_step1[d] = 1'b0;
          off_step2[d] = 1'b1;
        end else if (off_step2[d]) begin
          if (switch_i[d]) begin
            log_error($sformatf("domain %0d switch did not fall after reset", d));
          end
          off_step2[d] = 1'b0;
        end
        if (iso_i[d] && !iso_q[d]) begin
          off_step1[d] = 1'b1;
        end
      end
      sw_q  = switch_i;
      iso_q = iso_i;
      rst_q = dom_rst_n_i;
      ack_q = ack_i;
      if (valid_i && write_i && addr_i == ADDR_PWR_CTRL) begin
        req_m = wdata_i[NUM_DOMAINS-1:0];
      end
    end
  end

endmodule

/* test/tb_ext_periph.sv */
// Testbench for the external peripheral block. Applies a table of bus
// accesses, GPIO edges and status waits; a checker module does the comparing.
module tb_ext_periph;

  localparam int NUM_DOMAINS        = 2;
  localparam int CLK_PERIOD         = 40;
  localparam int RESET_CYCLES       = 10;
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int CYCLES_PER_ROW     = 40;
  localparam int POLL_LIMIT         = 60;

  localparam logic [11:0] ADDR_PWR_CTRL   = 12'h000;
  localparam logic [11:0] ADDR_PWR_STATUS = 12'h004;
  localparam logic [11:0] ADDR_GPIO_MAX   = 12'h100;
  localparam logic [11:0] ADDR_GPIO_COUNT = 12'h104;

  localparam logic [1:0] K_WRITE = 2'd0;
  localparam logic [1:0] K_READ  = 2'd1;
  localparam logic [1:0] K_EDGES = 2'd2;
  localparam logic [1:0] K_WAIT  = 2'd3;

  // For waits, data is the status mask and exp_rdata the masked value
  typedef struct packed {
    logic [1:0]  kind;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] exp_rdata;
    logic        exp_error;
    logic [7:0]  edges;
  } row_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   reg_valid_i;
  logic                   reg_write_i;
  logic [11:0]            reg_addr_i;
  logic [31:0]            reg_wdata_i;
  logic [31:0]            reg_rdata_o;
  logic                   reg_error_o;
  logic [NUM_DOMAINS-1:0] switch_ack_i;
  logic [NUM_DOMAINS-1:0] switch_o;
  logic [NUM_DOMAINS-1:0] iso_o;
  logic [NUM_DOMAINS-1:0] dom_rst_n_o;
  logic                   gpio_i;
  logic                   gpio_o;
  logic                   chk_en;
  logic [31:0]            exp_rdata;
  logic                   exp_error;

  logic [NUM_DOMAINS-1:0][SWITCH_ACK_LATENCY-1:0] ack_sr;
  row_t        rows[$];
  logic [31:0] lfsr_state;
  int          tb_errors;
  int          chk_errors;
  bit          table_ready;

  always #(CLK_PERIOD / 2) clk_i = !clk_i;

  // Switch cells modelled as a fixed delay from switch to acknowledge
  always @(posedge clk_i) begin
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      if (!rst_n_i) begin
        ack_sr[d] <= '0;
      end else begin
        ack_sr[d] <= {ack_sr[d][SWITCH_ACK_LATENCY-2:0], switch_o[d]};
      end
    end
  end

  always_comb begin
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      switch_ack_i[d] = ack_sr[d][SWITCH_ACK_LATENCY-1];
    end
  end

  ext_periph_top #(.NUM_DOMAINS(NUM_DOMAINS)) ext_periph_top_i (.*);

  ext_periph_checker #(.NUM_DOMAINS(NUM_DOMAINS)) checker_i (
    .clk_i, .rst_n_i,
    .valid_i (reg_valid_i), .write_i (reg_write_i),
    .addr_i (reg_addr_i), .wdata_i (reg_wdata_i),
    .rdata_i (reg_rdata_o), .error_i (reg_error_o),
    .ack_i (switch_ack_i), .switch_i (switch_o),
    .iso_i (iso_o), .dom_rst_n_i (dom_rst_n_o),
    .gpio_in_i (gpio_i), .gpio_out_i (gpio_o),
    .chk_en_i (chk_en), .exp_rdata_i (exp_rdata), .exp_error_i (exp_error),
    .err_cnt_o (chk_errors)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic void add_row(input logic [1:0] kind, input logic [11:0] addr,
                                  input logic [31:0] data, input logic [31:0] exp_rd,
                                  input logic exp_err, input logic [7:0] edges);
    row_t r;
    r = '{kind, addr, data, exp_rd, exp_err, edges};
    rows.push_back(r);
  endfunction

  task automatic build_table();
    logic [15:0] limit;
    logic [15:0] edges;
    logic [15:0] rem;
    add_row(K_READ, ADDR_GPIO_MAX, 0, 32'd4, 1'b0, 0);
    add_row(K_READ, ADDR_PWR_STATUS, 0, 0, 1'b0, 0);
    add_row(K_WRITE, ADDR_GPIO_MAX, 32'd9, 0, 1'b0, 0);
    add_row(K_READ, ADDR_GPIO_MAX, 0, 32'd9, 1'b0, 0);
    add_row(K_WRITE, ADDR_PWR_STATUS, 32'hff, 0, 1'b0, 0);
    add_row(K_READ, ADDR_PWR_STATUS, 0, 0, 1'b0, 0);
    // Unmapped region and unknown offsets
    add_row(K_READ, 12'h200, 0, 0, 1'b1, 0);
    add_row(K_WRITE, 12'h300, 32'h3, 0, 1'b1, 0);
    add_row(K_WRITE, 12'h008, 32'h3, 0, 1'b1, 0);
    add_row(K_WRITE, 12'h108, 32'h7, 0, 1'b1, 0);
    add_row(K_READ, 12'h10c, 0, 0, 1'b1, 0);
    add_row(K_READ, ADDR_GPIO_MAX, 0, 32'd9, 1'b0, 0);
    add_row(K_READ, ADDR_PWR_CTRL, 0, 0, 1'b0, 0);
    // Each domain on and off in turn
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      add_row(K_WRITE, ADDR_PWR_CTRL, 32'(1 << d), 0, 1'b0, 0);
      add_row(K_READ, ADDR_PWR_CTRL, 0, 32'(1 << d), 1'b0, 0);
      add_row(K_WAIT, 0, 32'(1 << d), 32'(1 << d), 1'b0, 0);
      add_row(K_READ, ADDR_PWR_STATUS, 0, 32'(1 << d), 1'b0, 0);
      add_row(K_WRITE, ADDR_PWR_CTRL, 0, 0, 1'b0, 0);
      add_row(K_WAIT, 0, 32'(1 << d), 0, 1'b0, 0);
      add_row(K_READ, ADDR_PWR_STATUS, 0, 0, 1'b0, 0);
    end
    // Zero limit counts as one
    add_row(K_WRITE, ADDR_GPIO_MAX, 0, 0, 1'b0, 0);
    add_row(K_EDGES, 0, 0, 0, 1'b0, 3);
    add_row(K_READ, ADDR_GPIO_COUNT, 0, 0, 1'b0, 0);
    for (int r = 0; r < 4; r++) begin
      limit = 16'd1 + take_bits(3);
      edges = take_bits(4);
      rem   = edges % limit;
      add_row(K_WRITE, ADDR_GPIO_MAX, 32'(limit), 0, 1'b0, 0);
      add_row(K_READ, ADDR_GPIO_MAX, 0, 32'(limit), 1'b0, 0);
      add_row(K_EDGES, 0, 0, 0, 1'b0, edges[7:0]);
      add_row(K_READ, ADDR_GPIO_COUNT, 0, 32'(rem), 1'b0, 0);
      // Bring the count back to zero before the next limit
      if (rem != 0) begin
        add_row(K_EDGES, 0, 0, 0, 1'b0, 8'(limit - rem));
        add_row(K_READ, ADDR_GPIO_COUNT, 0, 0, 1'b0, 0);
      end
    end
  endtask

  task automatic poll_status(input logic [31:0] mask, input logic [31:0] value);
    int  n;
    bit  done;
    n    = 0;
    done = 0;
    while (!done && n < POLL_LIMIT) begin
      @(posedge clk_i);
      reg_valid_i <= 1'b1;
      reg_write_i <= 1'b0;
      reg_addr_i  <= ADDR_PWR_STATUS;
      @(negedge clk_i);
      if ((reg_rdata_o & mask) == value) begin
        done = 1;
      end
      n++;
    end
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    if (!done) begin
      tb_errors++;
      $display("Status did not reach %h under mask %h within %0d cycles", value, mask,
               POLL_LIMIT);
    end
  endtask

  task automatic apply_row(input row_t r);
    case (r.kind)
      K_WRITE, K_READ: begin
        @(posedge clk_i);
        reg_valid_i <= 1'b1;
        reg_write_i <= (r.kind == K_WRITE);
        reg_addr_i  <= r.addr;
        reg_wdata_i <= r.data;
        chk_en      <= 1'b1;
        exp_rdata   <= r.exp_rdata;
        exp_error   <= r.exp_error;
        @(posedge clk_i);
        reg_valid_i <= 1'b0;
        reg_write_i <= 1'b0;
        chk_en      <= 1'b0;
      end
      K_EDGES: begin
        repeat (r.edges) begin
          @(posedge clk_i);
          gpio_i <= 1'b1;
          @(posedge clk_i);
          gpio_i <= 1'b0;
        end
      end
      default: poll_status(r.data, r.exp_rdata);
    endcase
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    gpio_i      = 1'b0;
    chk_en      = 1'b0;
    exp_rdata   = '0;
    exp_error   = 1'b0;
    ack_sr      = '0;
    tb_errors   = 0;
    lfsr_state  = 32'hc31e6e10;
    build_table();
    table_ready = 1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    repeat (5) @(posedge clk_i);
    $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #((rows.size() * CYCLES_PER_ROW + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not finish in the expected time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* project.f */
source/ext_periph_pkg.sv
source/reg_bus_if.sv
source/reg_demux.sv
source/power_ctrl_regs.sv
source/power_seq.sv
source/gpio_cnt.sv
source/ext_periph_top.sv
test/ext_periph_checker.sv
test/tb_ext_periph.sv

/* run.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_ext_periph -o sim_ext_periph \
  && ./obj_dir/sim_ext_periph > sim.log 2>&1 ; cat sim.log \
  && ! grep -q "Simulation FAILED" sim.log \
  && grep -q "Simulation PASSED" sim.log \
  || { echo "Run failed"; exit 1; }
